/* squeeze_defines.svh */
`ifndef SQUEEZE_DEFINES_SVH
`define SQUEEZE_DEFINES_SVH

// ----------------------------------------------------------------------
// data widths
// ----------------------------------------------------------------------
`define SQ_WORD_BITS     32	// host pipe word
`define SQ_RESULT_BITS   16	// engine result, zero-extended on the way in

// ----------------------------------------------------------------------
// FIFO sizing and block throttle
// ----------------------------------------------------------------------
`define SQ_FIFO_DEPTH    64	// words per FIFO, power of two
`define SQ_COUNT_BITS    7	// holds 0 .. SQ_FIFO_DEPTH
`define SQ_BLOCK_WORDS   16	// one host block transfer
`define SQ_HEADROOM      4	// margin for count update latency

// ----------------------------------------------------------------------
// scratch memory in the mover
// ----------------------------------------------------------------------
`define SQ_SCRATCH_WORDS 256
`define SQ_ADDR_BITS     8

`endif

/* squeeze_pkg.sv */
`include "squeeze_defines.svh"

package squeeze_pkg;

	typedef logic [`SQ_WORD_BITS-1:0]   word_t;
	typedef logic [`SQ_RESULT_BITS-1:0] result_t;
	typedef logic [`SQ_COUNT_BITS-1:0]  fifo_count_t;
	typedef logic [`SQ_ADDR_BITS-1:0]   scratch_addr_t;

	// control levels from the host wire endpoint
	typedef struct packed {
		logic reads_en;		// scratch -> pipe-out
		logic writes_en;	// pipe-in -> scratch
		logic writeback_en;	// result fifo -> scratch, implies a write
		logic dma_reset;	// pipe fifos and mover
		logic engine_reset;	// result fifo
	} host_ctrl_t;

	// FIFO fill state, 9 bits
	typedef struct packed {
		logic        empty;
		logic        full;
		fifo_count_t count;
	} fifo_status_t;

	// write path of the port-0 mover
	typedef enum logic [1:0] {
		MV_IDLE,
		MV_WRITE,
		MV_WAIT_VALID
	} mover_state_t;

endpackage

/* word_fifo.sv */
`timescale 1ns/1ps
`include "squeeze_defines.svh"

module word_fifo import squeeze_pkg::*; (
	input  logic         okClk,
	input  logic         reset,
	input  logic         wr_en,
	input  logic         rd_en,
	input  word_t        din,
	output word_t        dout,
	output logic         valid,
	output fifo_status_t status
);

	localparam int PTR_BITS = $clog2(`SQ_FIFO_DEPTH);

	word_t               mem [0:`SQ_FIFO_DEPTH-1];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	fifo_count_t         count;
	logic                do_wr;
	logic                do_rd;

	assign do_wr = wr_en && !status.full;
	assign do_rd = rd_en && !status.empty;

	// flags come off the count register, so they trail the access by a cycle
	assign status.empty = (count == '0);
	assign status.full  = (count == fifo_count_t'(`SQ_FIFO_DEPTH));
	assign status.count = count;

	always_ff @(posedge okClk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
		if (do_rd) begin
			dout <= mem[rd_ptr];	// read latency one
		end
	end

	always_ff @(posedge okClk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_rd;
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;	// wraps, depth is a power of two
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// protocol checks on the producer and the consumer
	// ----------------------------------------------------------------------
	a_no_write_full: assert property (@(posedge okClk) disable iff (reset)
		!(wr_en && status.full))
		else $error("word_fifo: write while full");

	a_no_read_empty: assert property (@(posedge okClk) disable iff (reset)
		!(rd_en && status.empty))
		else $error("word_fifo: read while empty");

endmodule

/* host_flow_ctrl.sv */
`timescale 1ns/1ps
`include "squeeze_defines.svh"

module host_flow_ctrl import squeeze_pkg::*; (
	input  logic         okClk,
	input  logic         reset,
	input  host_ctrl_t   ctrl,
	input  fifo_status_t pi_status,
	input  fifo_status_t po_status,
	input  fifo_status_t res_status,
	input  logic         mover_busy,
	output logic         pipe_in_ready,
	output logic         pipe_out_ready,
	output logic [7:0]   led
);

	// room for a full block plus the count latency margin
	localparam fifo_count_t PI_READY_MAX =
		fifo_count_t'(`SQ_FIFO_DEPTH - `SQ_HEADROOM - `SQ_BLOCK_WORDS);
	localparam fifo_count_t PO_READY_MIN = fifo_count_t'(`SQ_BLOCK_WORDS);

	logic [7:0] led_status;

	assign led_status = {
		pi_status.full,
		pi_status.empty,
		po_status.full,
		po_status.empty,
		res_status.full,
		ctrl.writes_en,
		ctrl.reads_en,
		mover_busy
	};

	// ----------------------------------------------------------------------
	// block throttle
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset) begin
			pipe_in_ready  <= 1'b1;	// fifos come out of reset empty
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready  <= (pi_status.count <= PI_READY_MAX);
			pipe_out_ready <= (po_status.count >= PO_READY_MIN);
		end
	end

	// ----------------------------------------------------------------------
	// status LEDs, active low
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset) begin
			led <= 8'hff;	// all off
		end else begin
			led <= ~led_status;	// 8'haf with both pipes empty and ctrl low
		end
	end

endmodule

/* scratch_dma.sv */
`timescale 1ns/1ps
`include "squeeze_defines.svh"

module scratch_dma import squeeze_pkg::*; (
	input  logic         okClk,
	input  logic         reset,
	input  host_ctrl_t   ctrl,
	input  word_t        pi_data,
	input  word_t        res_word,
	input  logic         pi_valid,
	input  logic         res_valid,
	input  fifo_status_t pi_status,
	input  fifo_status_t res_status,
	input  fifo_status_t po_status,
	output logic         pi_rd_en,
	output logic         res_rd_en,
	output logic         po_wr_en,
	output word_t        po_din,
	output logic         busy
);

	localparam logic [`SQ_ADDR_BITS:0] SCRATCH_FULL =
		(`SQ_ADDR_BITS+1)'(`SQ_SCRATCH_WORDS);
	localparam fifo_count_t PO_LIMIT = fifo_count_t'(`SQ_FIFO_DEPTH - `SQ_HEADROOM);

	word_t                  scratch_mem [0:`SQ_SCRATCH_WORDS-1];
	mover_state_t           state;
	logic                   src_sel_q;	// 1: result fifo, held for one transfer
	logic [`SQ_ADDR_BITS:0] stored_cnt;	// words written into scratch
	logic [`SQ_ADDR_BITS:0] read_cnt;	// words read out of scratch
	logic [`SQ_ADDR_BITS:0] unread;
	scratch_addr_t          wr_addr;
	scratch_addr_t          rd_addr;
	logic                   write_lvl;
	logic                   src_empty_now;
	logic                   src_empty_q;
	logic                   src_valid;
	word_t                  src_data;
	logic                   write_go;
	logic                   store;
	logic                   rd_issue;
	logic                   rd_valid;
	word_t                  rd_data;

	assign unread  = stored_cnt - read_cnt;
	assign wr_addr = stored_cnt[`SQ_ADDR_BITS-1:0];	// modulo scratch size
	assign rd_addr = read_cnt[`SQ_ADDR_BITS-1:0];

	// ----------------------------------------------------------------------
	// inbound source select
	// ----------------------------------------------------------------------
	assign write_lvl     = ctrl.writes_en || ctrl.writeback_en;
	assign src_empty_now = ctrl.writeback_en ? res_status.empty : pi_status.empty;
	assign src_empty_q   = src_sel_q ? res_status.empty : pi_status.empty;
	assign src_valid     = src_sel_q ? res_valid : pi_valid;
	assign src_data      = src_sel_q ? res_word : pi_data;

	// only the latched source sees a read strobe
	assign pi_rd_en  = (state == MV_WRITE) && !src_sel_q && !pi_status.empty;
	assign res_rd_en = (state == MV_WRITE) && src_sel_q && !res_status.empty;

	// ----------------------------------------------------------------------
	// write path, one source read at a time
	// ----------------------------------------------------------------------
	assign write_go = write_lvl && !src_empty_now && (unread != SCRATCH_FULL);
	assign store    = (state == MV_WAIT_VALID) && src_valid;

	always_ff @(posedge okClk) begin
		if (reset) begin
			state      <= MV_IDLE;
			src_sel_q  <= 1'b0;
			stored_cnt <= '0;
		end else begin
			case (state)
				MV_IDLE: begin
					if (write_go) begin
						state     <= MV_WRITE;
						src_sel_q <= ctrl.writeback_en;	// fixed until the word lands
					end
				end
				MV_WRITE: begin
					state <= src_empty_q ? MV_IDLE : MV_WAIT_VALID;
				end
				MV_WAIT_VALID: begin
					if (src_valid) begin
						state      <= MV_IDLE;
						stored_cnt <= stored_cnt + 1'b1;
					end else if (src_sel_q && ctrl.engine_reset) begin
						state <= MV_IDLE;	// result fifo cleared under us
					end
				end
				default: state <= MV_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// read path to pipe-out
	// ----------------------------------------------------------------------
	// the po count lags two writes behind, headroom covers them
	assign rd_issue = ctrl.reads_en && (unread != '0) && (po_status.count < PO_LIMIT);

	always_ff @(posedge okClk) begin
		if (store) begin
			scratch_mem[wr_addr] <= src_data;
		end
		if (rd_issue) begin
			rd_data <= scratch_mem[rd_addr];
		end
	end

	always_ff @(posedge okClk) begin
		if (reset) begin
			read_cnt <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_issue;
			if (rd_issue) begin
				read_cnt <= read_cnt + 1'b1;
			end
		end
	end

	assign po_wr_en = rd_valid;	// one cycle after the scratch read
	assign po_din   = rd_data;
	assign busy     = (state != MV_IDLE) || rd_valid;

	// write path throttle and read path accounting keep the scratch bounded
	a_scratch_bound: assert property (@(posedge okClk) disable iff (reset)
		unread <= SCRATCH_FULL)
		else $error("scratch_dma: scratch overrun, unread=%0d", unread);

endmodule

/* squeeze_host_top.sv */
`timescale 1ns/1ps
`include "squeeze_defines.svh"

module squeeze_host_top import squeeze_pkg::*; (
	input  logic       okClk,
	input  logic       reset,
	input  host_ctrl_t ctrl,
	input  logic       pi_write,
	input  word_t      pi_data,
	input  logic       po_read,
	input  logic       res_write,
	input  result_t    res_data,
	output word_t      po_data,
	output logic       po_valid,
	output logic       pipe_in_ready,
	output logic       pipe_out_ready,
	output logic [7:0] led
);

	logic         pipe_rst;
	logic         res_rst;
	word_t        res_din;

	word_t        pi_dout;
	logic         pi_valid;
	logic         pi_rd_en;
	fifo_status_t pi_status;

	word_t        res_dout;
	logic         res_valid;
	logic         res_rd_en;
	fifo_status_t res_status;

	logic         po_wr_en;
	word_t        po_din;
	fifo_status_t po_status;

	logic         mover_busy;

	assign pipe_rst = reset || ctrl.dma_reset;
	assign res_rst  = reset || ctrl.engine_reset;
	assign res_din  = {{(`SQ_WORD_BITS-`SQ_RESULT_BITS){1'b0}}, res_data};

	// ----------------------------------------------------------------------
	// buffers
	// ----------------------------------------------------------------------
	word_fifo pipe_in_fifo (
		.okClk  (okClk),
		.reset  (pipe_rst),
		.wr_en  (pi_write),	// host honours pipe_in_ready
		.rd_en  (pi_rd_en),
		.din    (pi_data),
		.dout   (pi_dout),
		.valid  (pi_valid),
		.status (pi_status)
	);

	word_fifo pipe_out_fifo (
		.okClk  (okClk),
		.reset  (pipe_rst),
		.wr_en  (po_wr_en),
		.rd_en  (po_read),
		.din    (po_din),
		.dout   (po_data),
		.valid  (po_valid),
		.status (po_status)
	);

	word_fifo result_fifo (
		.okClk  (okClk),
		.reset  (res_rst),
		.wr_en  (res_write),
		.rd_en  (res_rd_en),
		.din    (res_din),
		.dout   (res_dout),
		.valid  (res_valid),
		.status (res_status)
	);

	// ----------------------------------------------------------------------
	// port-0 mover and host flow control
	// ----------------------------------------------------------------------
	scratch_dma mover (
		.okClk      (okClk),
		.reset      (pipe_rst),
		.ctrl       (ctrl),
		.pi_data    (pi_dout),
		.res_word   (res_dout),
		.pi_valid   (pi_valid),
		.res_valid  (res_valid),
		.pi_status  (pi_status),
		.res_status (res_status),
		.po_status  (po_status),
		.pi_rd_en   (pi_rd_en),
		.res_rd_en  (res_rd_en),
		.po_wr_en   (po_wr_en),
		.po_din     (po_din),
		.busy       (mover_busy)
	);

	host_flow_ctrl flow_ctrl (
		.okClk          (okClk),
		.reset          (reset),
		.ctrl           (ctrl),
		.pi_status      (pi_status),
		.po_status      (po_status),
		.res_status     (res_status),
		.mover_busy     (mover_busy),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_ready (pipe_out_ready),
		.led            (led)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic okClk
);

	initial begin
		okClk = 1'b0;
		forever begin
			#2 okClk = ~okClk;	// 4 ns period
		end
	end

endmodule

/* squeeze_host_tb.sv */
`timescale 1ns/1ps

module squeeze_host_tb import squeeze_pkg::*; ();

	localparam int WAIT_LIMIT = 500;	// cycles per wait loop

	logic       okClk;
	logic       reset;
	host_ctrl_t ctrl;
	logic       pi_write;
	word_t      pi_data;
	logic       po_read;
	logic       res_write;
	result_t    res_data;
	word_t      po_data;
	logic       po_valid;
	logic       pipe_in_ready;
	logic       pipe_out_ready;
	logic [7:0] led;

	tb_clock_gen clk_gen (
		.okClk (okClk)
	);

	squeeze_host_top dut_i (
		.okClk          (okClk),
		.reset          (reset),
		.ctrl           (ctrl),
		.pi_write       (pi_write),
		.pi_data        (pi_data),
		.po_read        (po_read),
		.res_write      (res_write),
		.res_data       (res_data),
		.po_data        (po_data),
		.po_valid       (po_valid),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_ready (pipe_out_ready),
		.led            (led)
	);

	// ----------------------------------------------------------------------
	// timing and error helpers
	// ----------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge okClk);
		#1;	// drive and sample just after the edge
	endtask

	// ready flags and led trail the fill counts by two edges
	task automatic settle_flags();
		next_cycle();
		next_cycle();
	endtask

	task automatic stop_on_error(input string msg);
		$display("SIMULATION FAILED");
		$display("%s", msg);
		$fatal(1, "stopped at first error");
	endtask

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch led: got %h, expected %h", got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// ----------------------------------------------------------------------
	// timed waits
	// ----------------------------------------------------------------------
	task automatic wait_out_ready();
		int n;
		n = 0;
		settle_flags();
		while (pipe_out_ready !== 1'b1) begin
			if (n == WAIT_LIMIT) begin
				stop_on_error("timed out waiting for pipe_out_ready to rise");
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_in_ready_low();
		int n;
		n = 0;
		settle_flags();
		while (pipe_in_ready !== 1'b0) begin
			if (n == WAIT_LIMIT) begin
				stop_on_error("timed out waiting for pipe_in_ready to fall");
			end
			next_cycle();
			n++;
		end
	endtask

	// led bit 4 is high while the pipe-out FIFO holds a word
	task automatic wait_out_data();
		int n;
		n = 0;
		next_cycle();	// let the led catch up with the last read
		while (led[4] !== 1'b1) begin
			if (n == WAIT_LIMIT) begin
				stop_on_error("timed out waiting for a word in the pipe-out FIFO");
			end
			next_cycle();
			n++;
		end
	endtask

	// ----------------------------------------------------------------------
	// host bursts, incrementing from the first word
	// ----------------------------------------------------------------------
	task automatic write_pipe_in(input word_t first, input int count);
		for (int i = 0; i < count; i++) begin
			if (pipe_in_ready !== 1'b1) begin
				stop_on_error("host wrote to pipe-in while pipe_in_ready was low");
			end
			pi_write = 1'b1;
			pi_data  = first + word_t'(i);
			next_cycle();
		end
		pi_write = 1'b0;
	endtask

	task automatic write_results(input word_t first, input int count);
		for (int i = 0; i < count; i++) begin
			res_write = 1'b1;
			res_data  = result_t'(first + word_t'(i));	// engine result is 16 bits
			next_cycle();
		end
		res_write = 1'b0;
	endtask

	task automatic read_pipe_out(input word_t first, input int count);
		word_t exp;
		for (int i = 0; i < count; i++) begin
			exp = first + word_t'(i);
			wait_out_data();
			po_read = 1'b1;
			next_cycle();
			po_read = 1'b0;
			check_flag("po_valid", po_valid, 1'b1);	// one cycle after po_read
			check_word("po_data", po_data, exp);
		end
	endtask

	task automatic run_op(input logic [7:0] op, input word_t value, input word_t count);
		case (op)
			"C": begin
				ctrl = host_ctrl_t'(value[4:0]);
				next_cycle();
			end
			"W": write_pipe_in(value, int'(count));
			"E": write_results(value, int'(count));
			"R": read_pipe_out(value, int'(count));
			"L": begin
				settle_flags();
				check_led(led, value[7:0]);
			end
			"F": begin
				settle_flags();
				check_flag("pipe_in_ready", pipe_in_ready, value[1]);
				check_flag("pipe_out_ready", pipe_out_ready, value[0]);
			end
			"P": wait_out_ready();
			"N": wait_in_ready_low();
			default: stop_on_error($sformatf("unknown opcode %s in the stimulus file", op));
		endcase
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int         fd;
		int         n;
		logic [7:0] op;
		word_t      value;
		word_t      count;
		string      line;

		reset       = 1'b1;
		ctrl        = '0;
		pi_write    = 1'b0;
		pi_data     = '0;
		po_read     = 1'b0;
		res_write   = 1'b0;
		res_data    = '0;

		fd = $fopen("squeeze_stim.txt", "r");
		if (fd == 0) begin
			stop_on_error("cannot open squeeze_stim.txt");
		end

		repeat (16) next_cycle();
		reset = 1'b0;
		next_cycle();

		while (!$feof(fd)) begin
			n = $fscanf(fd, " %c", op);
			if (n != 1) begin
				break;	// end of file
			end
			if (op == "#") begin
				n = $fgets(line, fd);	// comment line
			end else begin
				n = $fscanf(fd, " %h %h", value, count);
				if (n != 2) begin
					stop_on_error("malformed line in squeeze_stim.txt");
				end
				run_op(op, value, count);
			end
		end
		$fclose(fd);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* squeeze_stim.txt */
# op value count, value and count in hex, count only used by W E R
# C ctrl, W/E/R bursts from value upward, L led, F {in,out} ready, P/N waits
F 2 1
L af 1
C 18 1
W 10000000 10
F 2 1
P 0 1
R 10000000 10
L a9 1
C 10 1
W 20000000 2d
N 0 1
L ed 1
E 0000c000 10
C 14 1
P 0 1
R 0000c000 10
L ed 1
F 0 1
C 18 1
P 0 1
R 20000000 2d
L a9 1
W 30000000 10
P 0 1
C 00 1
W 40000000 2d
N 0 1
L ff 1
C 02 1
C 00 1
L af 1
F 2 1
C 18 1
W 50000000 2
R 50000000 2
L a9 1

/* list.f */
+incdir+.
squeeze_pkg.sv
word_fifo.sv
host_flow_ctrl.sv
scratch_dma.sv
squeeze_host_top.sv
tb_clock_gen.sv
squeeze_host_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
	--top-module squeeze_host_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vsqueeze_host_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
